//--- src/me_pkg.sv
package me_pkg;

    localparam int block_dim    = 4;
    localparam int search_dim   = 8;
    localparam int range_dim    = search_dim - block_dim + 1;  // positions per axis
    localparam int block_pixels = block_dim * block_dim;

    localparam int pix_w  = 8;
    localparam int sad_w  = 12;  // holds 16 * 255
    localparam int addr_w = 6;

    // which memory answers the read strobe
    typedef enum logic
    {
        src_cur,
        src_ref
    } pix_src_e;

    // command for one pixel cycle
    typedef struct packed
    {
        logic       load_cur;    // write pixel into cpr
        logic       accumulate;  // add abs diff to the running sum
        logic       last_pixel;  // closes the candidate
        logic [3:0] pixel;       // index inside the block
        logic [2:0] mv_x;
        logic [2:0] mv_y;
    } me_step_t;

    typedef struct packed
    {
        logic [2:0]       mv_x;
        logic [2:0]       mv_y;
        logic [sad_w-1:0] sad;
    } me_result_t;

endpackage

//--- src/me_controller.sv
`timescale 1ns/1ps

module me_controller
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      done,
    output logic                      ready,
    output logic                      pix_rd,
    output me_pkg::pix_src_e          pix_src,
    output logic [me_pkg::addr_w-1:0] pix_addr,
    output me_pkg::me_step_t          step
);
    import me_pkg::*;

    typedef enum logic [1:0]
    {
        idle,
        load,
        search,
        drain
    } state_e;

    state_e     state;
    logic [3:0] pix_cnt;
    logic [2:0] mv_x;
    logic [2:0] mv_y;
    logic [1:0] blk_row;
    logic [1:0] blk_col;
    logic [2:0] win_row;
    logic [2:0] win_col;
    logic       last_pix;
    logic       last_cand;

    assign last_pix  = (pix_cnt == 4'(block_pixels - 1));
    assign last_cand = (mv_x == 3'(range_dim - 1)) && (mv_y == 3'(range_dim - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= idle;
            pix_cnt <= '0;
            mv_x    <= '0;
            mv_y    <= '0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (start)
                        state <= load;
                end
                load:
                begin
                    pix_cnt <= pix_cnt + 1'b1;  // wraps to 0 for the search
                    if (last_pix)
                        state <= search;
                end
                search:
                begin
                    pix_cnt <= pix_cnt + 1'b1;
                    if (last_pix)
                    begin
                        if (last_cand)
                        begin
                            mv_x  <= '0;
                            mv_y  <= '0;
                            state <= drain;
                        end
                        else if (mv_x == 3'(range_dim - 1))
                        begin
                            mv_x <= '0;
                            mv_y <= mv_y + 1'b1;  // next row of candidates
                        end
                        else
                        begin
                            mv_x <= mv_x + 1'b1;
                        end
                    end
                end
                drain:
                begin
                    if (done)  // wait for the tracker
                        state <= idle;
                end
                default:
                    state <= idle;
            endcase
        end
    end

    assign blk_row = 2'(pix_cnt / block_dim);
    assign blk_col = 2'(pix_cnt % block_dim);
    assign win_row = mv_y + 3'(blk_row);
    assign win_col = mv_x + 3'(blk_col);

    assign ready   = (state == idle);
    assign pix_rd  = (state == load) || (state == search);
    assign pix_src = (state == search) ? src_ref : src_cur;

    always_comb
    begin
        if (state == search)
            pix_addr = addr_w'(win_row * search_dim + win_col);
        else
            pix_addr = addr_w'(blk_row * block_dim + blk_col);
    end

    always_comb
    begin
        step            = '0;
        step.load_cur   = (state == load);
        step.accumulate = (state == search);
        step.last_pixel = (state == search) && last_pix;
        step.pixel      = pix_cnt;
        step.mv_x       = mv_x;
        step.mv_y       = mv_y;
    end

endmodule

//--- src/sad_datapath.sv
`timescale 1ns/1ps

module sad_datapath
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  me_pkg::me_step_t         step,
    input  logic [me_pkg::pix_w-1:0] pix_data,
    output logic                     sad_valid,
    output me_pkg::me_result_t       cand
);
    import me_pkg::*;

    me_step_t         step_q;  // aligned with pix_data
    logic [pix_w-1:0] cpr [block_pixels];
    logic [pix_w-1:0] cur_pix;
    logic [pix_w-1:0] abs_diff;
    logic [sad_w-1:0] acc;
    logic [sad_w-1:0] acc_next;
    logic             close_cand;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            step_q <= '0;
        else
            step_q <= step;
    end

    always_ff @(posedge clk)
    begin
        if (step_q.load_cur)
            cpr[step_q.pixel] <= pix_data;
    end

    assign cur_pix  = cpr[step_q.pixel];
    assign abs_diff = (pix_data > cur_pix) ? (pix_data - cur_pix) : (cur_pix - pix_data);

    // first pixel of a candidate restarts the sum
    assign acc_next = (step_q.pixel == '0) ? sad_w'(abs_diff) : acc + sad_w'(abs_diff);

    assign close_cand = step_q.accumulate && step_q.last_pixel;

    always_ff @(posedge clk)
    begin
        if (step_q.accumulate)
            acc <= acc_next;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sad_valid <= 1'b0;
        else
            sad_valid <= close_cand;
    end

    always_ff @(posedge clk)
    begin
        if (close_cand)
        begin
            cand.mv_x <= step_q.mv_x;
            cand.mv_y <= step_q.mv_y;
            cand.sad  <= acc_next;  // includes the last difference
        end
    end

endmodule

//--- src/best_match_tracker.sv
`timescale 1ns/1ps

module best_match_tracker
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sad_valid,
    input  me_pkg::me_result_t cand,
    output logic               done,
    output me_pkg::me_result_t best
);
    import me_pkg::*;

    logic first_cand;
    logic last_cand;
    logic better;

    assign first_cand = (cand.mv_x == '0) && (cand.mv_y == '0);
    assign last_cand  = (cand.mv_x == 3'(range_dim - 1)) && (cand.mv_y == 3'(range_dim - 1));

    // strict compare keeps the first minimum in raster order
    assign better = first_cand || (cand.sad < best.sad);

    always_ff @(posedge clk)
    begin
        if (sad_valid && better)
            best <= cand;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            done <= 1'b0;
        else
            done <= sad_valid && last_cand;  // one cycle after (4,4)
    end

endmodule

//--- src/motion_search_top.sv
`timescale 1ns/1ps

module motion_search_top
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    output logic                      ready,
    output logic                      pix_rd,
    output me_pkg::pix_src_e          pix_src,
    output logic [me_pkg::addr_w-1:0] pix_addr,
    input  logic [me_pkg::pix_w-1:0]  pix_data,
    output logic                      done,
    output me_pkg::me_result_t        best
);
    import me_pkg::*;

    me_step_t   step;
    logic       sad_valid;
    me_result_t cand;

    // decode
    me_controller u_ctrl
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .done     (done),
        .ready    (ready),
        .pix_rd   (pix_rd),
        .pix_src  (pix_src),
        .pix_addr (pix_addr),
        .step     (step)
    );

    // execute
    sad_datapath u_sad
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .pix_data  (pix_data),
        .sad_valid (sad_valid),
        .cand      (cand)
    );

    // result
    best_match_tracker u_best
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .sad_valid (sad_valid),
        .cand      (cand),
        .done      (done),
        .best      (best)
    );

endmodule

//--- test/motion_search_assert.sv
`timescale 1ns/1ps

module motion_search_assert
(
    input logic             clk,
    input logic             rst_n,
    input logic             start,
    input logic             ready,
    input logic             pix_rd,
    input me_pkg::me_step_t step
);
    // idle holds with the strobe low until a start arrives
    idle_no_read: assert property (@(posedge clk) disable iff (!rst_n)
        ready && !start |=> ready && !pix_rd)
        else $error("controller left idle or raised pix_rd without a start");

    acc_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        step.accumulate && !step.last_pixel |=> step.accumulate && pix_rd)
        else $error("accumulate steps of a candidate broke off before its last pixel");

    // a read burst only begins after a start taken in idle
    start_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pix_rd) |-> $past(start && ready))
        else $error("search began without a start accepted in idle");

endmodule

bind me_controller motion_search_assert u_assert
(
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .ready  (ready),
    .pix_rd (pix_rd),
    .step   (step)
);

//--- test/motion_search_tb.sv
`timescale 1ns/1ps

module motion_search_tb;
    import me_pkg::*;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic              ready;
    logic              pix_rd;
    pix_src_e          pix_src;
    logic [addr_w-1:0] pix_addr;
    logic [pix_w-1:0]  pix_data;
    logic              done;
    me_result_t        best;
    logic [pix_w-1:0]  cur_mem [block_pixels];
    logic [pix_w-1:0]  ref_mem [search_dim * search_dim];
    int                done_count;

    motion_search_top uut
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .ready    (ready),
        .pix_rd   (pix_rd),
        .pix_src  (pix_src),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .done     (done),
        .best     (best)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)  // memories answer one cycle later
    begin
        if (pix_rd)
            pix_data <= (pix_src == src_ref) ? ref_mem[pix_addr] : cur_mem[pix_addr[3:0]];
    end

    always @(negedge clk)
    begin
        if (done)
            done_count <= done_count + 1;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopping after failure");
    endtask

    task automatic check_value(input string name, input int exp_val, input int act_val);
        if (exp_val != act_val)
        begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp_val, act_val);
            $display("Done: errors found");
            $fatal(1, "stopping after mismatch");
        end
    endtask

    task automatic check_result(input string name, input me_result_t exp_res);
        check_value({name, " mv_x"}, int'(exp_res.mv_x), int'(best.mv_x));
        check_value({name, " mv_y"}, int'(exp_res.mv_y), int'(best.mv_y));
        check_value({name, " sad"}, int'(exp_res.sad), int'(best.sad));
    endtask

    // full search in raster order keeping the first minimum
    task automatic compute_model(output me_result_t res);
        int sad;
        int best_sad;
        int a;
        int b;
        best_sad = 1 << 30;
        res = '0;
        for (int my = 0; my < range_dim; my++)
            for (int mx = 0; mx < range_dim; mx++)
            begin
                sad = 0;
                for (int r = 0; r < block_dim; r++)
                    for (int c = 0; c < block_dim; c++)
                    begin
                        a = int'(ref_mem[(my + r) * search_dim + mx + c]);
                        b = int'(cur_mem[r * block_dim + c]);
                        sad += (a > b) ? a - b : b - a;
                    end
                if (sad < best_sad)
                begin
                    best_sad = sad;
                    res.mv_x = 3'(mx);
                    res.mv_y = 3'(my);
                    res.sad  = sad_w'(sad);
                end
            end
    endtask

    task automatic fill_random();
        foreach (ref_mem[i])
            ref_mem[i] = 8'($urandom);
        foreach (cur_mem[i])
            cur_mem[i] = 8'($urandom);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!ready)
        begin
            if (cycles == 600)
                report_failure({name, ": timed out waiting for ready"});
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done)
        begin
            if (cycles == 600)
                report_failure({name, ": timed out waiting for done"});
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic run_search(input string name, input me_result_t exp_res);
        wait_ready(name);
        pulse_start();
        wait_done(name);
        check_result(name, exp_res);
    endtask

    task automatic zero_motion();
        fill_random();
        for (int r = 0; r < block_dim; r++)
            for (int c = 0; c < block_dim; c++)
                cur_mem[r * block_dim + c] = ref_mem[r * search_dim + c];
        run_search("zero_motion", '{mv_x: 3'd0, mv_y: 3'd0, sad: '0});
    endtask

    task automatic planted_match();
        fill_random();
        for (int r = 0; r < block_dim; r++)
            for (int c = 0; c < block_dim; c++)
                cur_mem[r * block_dim + c] = ref_mem[(r + 2) * search_dim + c + 3];
        run_search("planted_match", '{mv_x: 3'd3, mv_y: 3'd2, sad: '0});
    endtask

    task automatic uniform_ties();
        me_result_t res;
        fill_random();
        foreach (ref_mem[i])
            ref_mem[i] = 8'h5a;  // every candidate sees the same pixels
        compute_model(res);
        res.mv_x = 3'd0;
        res.mv_y = 3'd0;
        run_search("uniform_ties", res);
    endtask

    task automatic random_search();
        me_result_t res;
        fill_random();
        compute_model(res);
        run_search("random_search", res);
        @(negedge clk);
        check_value("random_search ready", 1, int'(ready));
    endtask

    task automatic busy_start();
        me_result_t res;
        fill_random();
        compute_model(res);
        wait_ready("busy_start");
        done_count = 0;
        pulse_start();
        repeat (100) @(posedge clk);
        pulse_start();  // ignored while busy
        wait_done("busy_start");
        check_result("busy_start", res);
        repeat (450) @(negedge clk);
        check_value("busy_start done count", 1, done_count);
        fill_random();
        compute_model(res);
        run_search("busy_start next", res);
    endtask

    task automatic reset_mid_search();
        me_result_t res;
        fill_random();
        wait_ready("reset_mid_search");
        pulse_start();
        repeat (100) @(posedge clk);  // well inside the search phase
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        done_count = 0;
        @(negedge clk);
        check_value("reset_mid_search ready", 1, int'(ready));
        repeat (450) @(negedge clk);
        check_value("reset_mid_search done count", 0, done_count);
        fill_random();
        compute_model(res);
        run_search("reset_mid_search fresh", res);
    endtask

    initial
    begin
        void'($urandom(8));
        rst_n      = 1'b0;
        start      = 1'b0;
        pix_data   = '0;
        done_count = 0;
        foreach (cur_mem[i])
            cur_mem[i] = '0;
        foreach (ref_mem[i])
            ref_mem[i] = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        zero_motion();
        planted_match();
        uniform_ties();
        random_search();
        busy_start();
        reset_mid_search();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- project.f
src/me_pkg.sv
src/me_controller.sv
src/sad_datapath.sv
src/best_match_tracker.sv
src/motion_search_top.sv
test/motion_search_assert.sv
test/motion_search_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module motion_search_tb -f project.f -o motion_search_sim

# the log decides the result, so the exit status of the simulator is not used here
./obj_dir/motion_search_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "simulation did not finish"
    exit 1
fi
echo "simulation passed"
